// File: build.f
+incdir+design
design/coh_msg_pkg.sv
design/coh_ctrl_pkg.sv
design/snoop_queue.sv
design/req_tracker.sv
design/snoop_ctrl.sv
design/msg_tx_arb.sv
design/msg_ctrl.sv
verification/msg_ctrl_tb.sv

// File: design/coh_ctrl_pkg.sv
`include "coh_params.svh"

package coh_ctrl_pkg;

    typedef enum logic [2:0] {
        acc_miss   = 3'd0,
        acc_clean  = 3'd1,
        acc_dirty  = 3'd2,
        acc_shared = 3'd3
    } acc_status_e;

    typedef enum logic [2:0] {
        cmd_lookup     = 3'd0,
        cmd_downgrade  = 3'd1,
        cmd_invalidate = 3'd2
    } acc_cmd_e;

    typedef struct packed {
        acc_cmd_e                cmd;
        logic [`ADDR_WIDTH-1:0]  index;
        logic [`TAG_WIDTH-1:0]   tag;
    } acc_req_t;

    typedef struct packed {
        acc_status_e             status;
        logic [`TAG_WIDTH-1:0]   tag;
        logic [`ADDR_WIDTH-1:0]  index;
    } acc_rsp_t;

    // dirty line writeback
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0]  addr;
        logic [`TAG_WIDTH-1:0]   tag;
    } fetch_req_t;

    typedef enum logic [1:0] {
        idle,
        bcast,
        wait_ack,
        done
    } trk_state_e;

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_wb_req,
        s_wb_wait,
        s_update,
        s_send,
        s_done
    } snp_state_e;

endpackage

// File: design/coh_msg_pkg.sv
`include "coh_params.svh"

package coh_msg_pkg;

    // bit 2 set marks a request
    typedef enum logic [3:0] {
        wr_ack       = 4'd0,
        rd_ack       = 4'd2,
        rd_share_ack = 4'd3,
        wr_req       = 4'd4,
        rd_req       = 4'd5
    } msg_op_e;

    typedef struct packed {
        msg_op_e                 op;
        logic [`ID_WIDTH-1:0]    ta;    // sender
        logic [`ID_WIDTH-1:0]    ra;    // receiver, all ones for broadcast
        logic [`ADDR_WIDTH-1:0]  addr;
    } coh_msg_t;

    typedef struct packed {
        msg_op_e                 op;    // rd_req or wr_req
        logic [`ADDR_WIDTH-1:0]  index;
    } local_req_t;

    typedef struct packed {
        msg_op_e op;
    } local_rsp_t;

endpackage

// File: design/coh_params.svh
`ifndef COH_PARAMS_SVH
`define COH_PARAMS_SVH

// line index width
`define ADDR_WIDTH 32

// caches in the snooping group
`define CACHE_NUM 4
`define ID_WIDTH 2

// tag returned by the cache array on lookup
`define TAG_WIDTH 2

// each peer has at most one read and one write outstanding
`define SNOOP_DEPTH (2 * `CACHE_NUM)

`endif

// File: design/msg_ctrl.sv
`timescale 1ns/1ps
`include "coh_params.svh"

module msg_ctrl #(
    parameter int cache_id = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_0,
    input  logic                     req_1,
    input  coh_msg_pkg::local_req_t  local_req_0,
    input  coh_msg_pkg::local_req_t  local_req_1,
    output logic                     gnt_0,
    output logic                     gnt_1,
    output coh_msg_pkg::local_rsp_t  rsp_0,
    output coh_msg_pkg::local_rsp_t  rsp_1,
    output logic                     rsp_valid_0,
    output logic                     rsp_valid_1,
    output logic                     acc_req,
    output coh_ctrl_pkg::acc_req_t   acc,
    input  logic                     acc_gnt,
    input  coh_ctrl_pkg::acc_rsp_t   acc_rsp,
    output logic                     fetch_req,
    output coh_ctrl_pkg::fetch_req_t fetch,
    input  logic                     fetch_gnt,
    input  logic                     fetch_done,
    output logic                     msg_req,
    input  logic                     msg_gnt,
    output coh_msg_pkg::coh_msg_t    msg,
    input  coh_msg_pkg::coh_msg_t    msg_in,
    input  logic                     msg_in_valid
);
    import coh_msg_pkg::*;

    localparam logic [`ID_WIDTH-1:0] ID = `ID_WIDTH'(cache_id);

    logic                   push;
    logic                   pop;
    coh_msg_t               head;
    logic                   not_empty;
    logic [`ADDR_WIDTH-1:0] wr_addr;
    logic [`ADDR_WIDTH-1:0] rd_addr;
    logic                   wr_hit;
    logic                   rd_hit;
    logic                   wr_gnt_0;
    logic                   wr_gnt_1;
    logic                   rd_gnt_0;
    logic                   rd_gnt_1;
    logic                   wr_rv_0;
    logic                   wr_rv_1;
    logic                   rd_rv_0;
    logic                   rd_rv_1;
    local_rsp_t             wr_rsp;
    local_rsp_t             rd_rsp;
    logic                   wr_tx_req;
    logic                   wr_tx_gnt;
    coh_msg_t               wr_tx_msg;
    logic                   rd_tx_req;
    logic                   rd_tx_gnt;
    coh_msg_t               rd_tx_msg;
    logic                   snp_tx_req;
    logic                   snp_tx_gnt;
    coh_msg_t               snp_tx_msg;

    // peer requests only, our own broadcasts come back too
    assign push = msg_in_valid && msg_in.op[2] && msg_in.ta != ID;

    snoop_queue snoop_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_msg  (msg_in),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .wr_addr   (wr_addr),
        .rd_addr   (rd_addr),
        .wr_hit    (wr_hit),
        .rd_hit    (rd_hit)
    );

    req_tracker #(.kind(wr_req)) wr_tracker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cache_id     (ID),
        .req_0        (req_0),
        .req_1        (req_1),
        .local_req_0  (local_req_0),
        .local_req_1  (local_req_1),
        .gnt_0        (wr_gnt_0),
        .gnt_1        (wr_gnt_1),
        .rsp_valid_0  (wr_rv_0),
        .rsp_valid_1  (wr_rv_1),
        .rsp          (wr_rsp),
        .addr_hit     (wr_hit),
        .tx_req       (wr_tx_req),
        .tx_gnt       (wr_tx_gnt),
        .tx_msg       (wr_tx_msg),
        .msg_in       (msg_in),
        .msg_in_valid (msg_in_valid),
        .held_addr    (wr_addr)
    );

    req_tracker #(.kind(rd_req)) rd_tracker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cache_id     (ID),
        .req_0        (req_0),
        .req_1        (req_1),
        .local_req_0  (local_req_0),
        .local_req_1  (local_req_1),
        .gnt_0        (rd_gnt_0),
        .gnt_1        (rd_gnt_1),
        .rsp_valid_0  (rd_rv_0),
        .rsp_valid_1  (rd_rv_1),
        .rsp          (rd_rsp),
        .addr_hit     (rd_hit),
        .tx_req       (rd_tx_req),
        .tx_gnt       (rd_tx_gnt),
        .tx_msg       (rd_tx_msg),
        .msg_in       (msg_in),
        .msg_in_valid (msg_in_valid),
        .held_addr    (rd_addr)
    );

    snoop_ctrl snoop_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cache_id   (ID),
        .head       (head),
        .not_empty  (not_empty),
        .pop        (pop),
        .acc_req    (acc_req),
        .acc        (acc),
        .acc_gnt    (acc_gnt),
        .acc_rsp    (acc_rsp),
        .fetch_req  (fetch_req),
        .fetch      (fetch),
        .fetch_gnt  (fetch_gnt),
        .fetch_done (fetch_done),
        .tx_req     (snp_tx_req),
        .tx_gnt     (snp_tx_gnt),
        .tx_msg     (snp_tx_msg)
    );

    msg_tx_arb msg_tx_arb_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_wr  (wr_tx_req),
        .req_rd  (rd_tx_req),
        .req_snp (snp_tx_req),
        .msg_wr  (wr_tx_msg),
        .msg_rd  (rd_tx_msg),
        .msg_snp (snp_tx_msg),
        .gnt_wr  (wr_tx_gnt),
        .gnt_rd  (rd_tx_gnt),
        .gnt_snp (snp_tx_gnt),
        .msg_req (msg_req),
        .msg_gnt (msg_gnt),
        .msg     (msg)
    );

    assign gnt_0 = wr_gnt_0 | rd_gnt_0;
    assign gnt_1 = wr_gnt_1 | rd_gnt_1;

    assign rsp_valid_0 = wr_rv_0 | rd_rv_0;
    assign rsp_valid_1 = wr_rv_1 | rd_rv_1;
    assign rsp_0       = wr_rv_0 ? wr_rsp : rd_rsp;
    assign rsp_1       = wr_rv_1 ? wr_rsp : rd_rsp;

endmodule

// File: design/msg_tx_arb.sv
`timescale 1ns/1ps
`include "coh_params.svh"

module msg_tx_arb (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_wr,
    input  logic                  req_rd,
    input  logic                  req_snp,
    input  coh_msg_pkg::coh_msg_t msg_wr,
    input  coh_msg_pkg::coh_msg_t msg_rd,
    input  coh_msg_pkg::coh_msg_t msg_snp,
    output logic                  gnt_wr,
    output logic                  gnt_rd,
    output logic                  gnt_snp,
    output logic                  msg_req,
    input  logic                  msg_gnt,
    output coh_msg_pkg::coh_msg_t msg
);
    logic [2:0] req;
    logic [1:0] last;       // last sender granted
    logic [1:0] lock_sel;
    logic       locked;
    logic [1:0] pick;
    logic [1:0] cur;

    assign req     = {req_snp, req_rd, req_wr};
    assign msg_req = |req;

    // first requester after the last winner
    always_comb begin
        int j;
        pick = last;
        for (int i = 3; i >= 1; i--) begin
            j = (int'(last) + i) % 3;
            if (req[j]) pick = 2'(j);
        end
    end

    assign cur = (locked && req[lock_sel]) ? lock_sel : pick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last     <= 2'd2;
            lock_sel <= 2'd0;
            locked   <= 1'b0;
        end else if (msg_req && msg_gnt) begin
            last   <= cur;
            locked <= 1'b0;
        end else begin
            locked   <= msg_req;
            lock_sel <= cur;
        end
    end

    assign gnt_wr  = msg_gnt && req_wr && cur == 2'd0;
    assign gnt_rd  = msg_gnt && req_rd && cur == 2'd1;
    assign gnt_snp = msg_gnt && req_snp && cur == 2'd2;

    always_comb begin
        case (cur)
            2'd0:    msg = msg_wr;
            2'd1:    msg = msg_rd;
            default: msg = msg_snp;
        endcase
    end

endmodule

// File: design/req_tracker.sv
`timescale 1ns/1ps
`include "coh_params.svh"

module req_tracker #(
    parameter coh_msg_pkg::msg_op_e kind = coh_msg_pkg::wr_req
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`ID_WIDTH-1:0]    cache_id,
    input  logic                    req_0,
    input  logic                    req_1,
    input  coh_msg_pkg::local_req_t local_req_0,
    input  coh_msg_pkg::local_req_t local_req_1,
    output logic                    gnt_0,
    output logic                    gnt_1,
    output logic                    rsp_valid_0,
    output logic                    rsp_valid_1,
    output coh_msg_pkg::local_rsp_t rsp,
    input  logic                    addr_hit,
    output logic                    tx_req,
    input  logic                    tx_gnt,
    output coh_msg_pkg::coh_msg_t   tx_msg,
    input  coh_msg_pkg::coh_msg_t   msg_in,
    input  logic                    msg_in_valid,
    output logic [`ADDR_WIDTH-1:0]  held_addr
);
    import coh_msg_pkg::*;
    import coh_ctrl_pkg::*;

    trk_state_e             state;
    trk_state_e             state_nxt;
    logic                   elig_0;
    logic                   elig_1;
    logic                   rr_ptr;     // port preferred on a tie
    logic                   owner;
    logic [`ADDR_WIDTH-1:0] index_q;
    logic [`CACHE_NUM-1:0]  ack_map;
    logic [`CACHE_NUM-1:0]  own_bit;
    logic                   share_seen;
    logic                   kind_ack;
    logic                   ack_in;

    assign elig_0 = req_0 && local_req_0.op == kind && state == idle;
    assign elig_1 = req_1 && local_req_1.op == kind && state == idle;
    assign gnt_0  = elig_0 && (!elig_1 || !rr_ptr);
    assign gnt_1  = elig_1 && (!elig_0 || rr_ptr);

    assign own_bit = {{(`CACHE_NUM-1){1'b0}}, 1'b1} << cache_id;

    always_comb begin
        if (kind == wr_req) begin
            kind_ack = msg_in.op == wr_ack;
        end else begin
            kind_ack = msg_in.op == rd_ack || msg_in.op == rd_share_ack;
        end
    end

    assign ack_in = msg_in_valid && kind_ack && state == wait_ack &&
                    msg_in.ra == cache_id && msg_in.addr == index_q;

    always_comb begin
        state_nxt = state;
        case (state)
            idle:     if (gnt_0 || gnt_1) state_nxt = bcast;
            bcast:    if (tx_req && tx_gnt) state_nxt = wait_ack;
            wait_ack: if (&ack_map) state_nxt = done;
            default:  state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            rr_ptr     <= 1'b0;
            ack_map    <= '0;
            share_seen <= 1'b0;
        end else begin
            state <= state_nxt;
            if (gnt_0 || gnt_1) begin
                rr_ptr <= gnt_0;    // other port wins next tie
            end
            if (state == idle) begin
                ack_map    <= own_bit;
                share_seen <= 1'b0;
            end else if (ack_in) begin
                ack_map[msg_in.ta] <= 1'b1;
                if (msg_in.op == rd_share_ack) begin
                    share_seen <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_0) begin
            owner   <= 1'b0;
            index_q <= local_req_0.index;
        end else if (gnt_1) begin
            owner   <= 1'b1;
            index_q <= local_req_1.index;
        end
    end

    // hold off while a peer request for the line is still queued
    assign tx_req = state == bcast && !addr_hit;

    always_comb begin
        tx_msg.op   = kind;
        tx_msg.ta   = cache_id;
        tx_msg.ra   = '1;
        tx_msg.addr = index_q;
    end

    assign rsp_valid_0 = state == done && !owner;
    assign rsp_valid_1 = state == done && owner;

    always_comb begin
        if (kind == wr_req) begin
            rsp.op = wr_ack;
        end else if (share_seen) begin
            rsp.op = rd_share_ack;
        end else begin
            rsp.op = rd_ack;
        end
    end

    assign held_addr = index_q;

endmodule

// File: design/snoop_ctrl.sv
`timescale 1ns/1ps
`include "coh_params.svh"

module snoop_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`ID_WIDTH-1:0]     cache_id,
    input  coh_msg_pkg::coh_msg_t    head,
    input  logic                     not_empty,
    output logic                     pop,
    output logic                     acc_req,
    output coh_ctrl_pkg::acc_req_t   acc,
    input  logic                     acc_gnt,
    input  coh_ctrl_pkg::acc_rsp_t   acc_rsp,
    output logic                     fetch_req,
    output coh_ctrl_pkg::fetch_req_t fetch,
    input  logic                     fetch_gnt,
    input  logic                     fetch_done,
    output logic                     tx_req,
    input  logic                     tx_gnt,
    output coh_msg_pkg::coh_msg_t    tx_msg
);
    import coh_msg_pkg::*;
    import coh_ctrl_pkg::*;

    snp_state_e             state;
    snp_state_e             state_nxt;
    acc_status_e            status_q;
    logic [`TAG_WIDTH-1:0]  tag_q;
    logic [`ADDR_WIDTH-1:0] idx_q;

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle: begin
                if (not_empty) state_nxt = s_lookup;
            end
            s_lookup: begin
                if (acc_gnt) begin
                    case (acc_rsp.status)
                        acc_dirty:              state_nxt = s_wb_req;
                        acc_clean, acc_shared:  state_nxt = s_update;
                        default:                state_nxt = s_send;
                    endcase
                end
            end
            s_wb_req: begin
                if (fetch_gnt) state_nxt = s_wb_wait;
            end
            s_wb_wait: begin
                if (fetch_done) state_nxt = s_update;
            end
            s_update: begin
                if (acc_gnt) state_nxt = s_send;
            end
            s_send: begin
                if (tx_gnt) state_nxt = s_done;
            end
            default: state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // lookup result for the rest of the sequence
    always_ff @(posedge clk) begin
        if (state == s_lookup && acc_gnt) begin
            status_q <= acc_rsp.status;
            tag_q    <= acc_rsp.tag;
            idx_q    <= acc_rsp.index;
        end
    end

    assign acc_req = state == s_lookup || state == s_update;

    always_comb begin
        if (state == s_lookup) begin
            acc.cmd   = cmd_lookup;
            acc.index = head.addr;
            acc.tag   = '0;
        end else begin
            acc.cmd   = head.op == wr_req ? cmd_invalidate : cmd_downgrade;
            acc.index = idx_q;
            acc.tag   = tag_q;
        end
    end

    assign fetch_req  = state == s_wb_req;
    assign fetch.addr = idx_q;
    assign fetch.tag  = tag_q;

    assign tx_req = state == s_send;

    always_comb begin
        tx_msg.ta   = cache_id;
        tx_msg.ra   = head.ta;
        tx_msg.addr = head.addr;
        if (head.op == wr_req) begin
            tx_msg.op = wr_ack;
        end else if (status_q != acc_miss) begin
            tx_msg.op = rd_share_ack;   // we kept a copy
        end else begin
            tx_msg.op = rd_ack;
        end
    end

    assign pop = state == s_done;

endmodule

// File: design/snoop_queue.sv
`timescale 1ns/1ps
`include "coh_params.svh"

module snoop_queue (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  coh_msg_pkg::coh_msg_t  push_msg,
    input  logic                   pop,
    output coh_msg_pkg::coh_msg_t  head,
    output logic                   not_empty,
    input  logic [`ADDR_WIDTH-1:0] wr_addr,
    input  logic [`ADDR_WIDTH-1:0] rd_addr,
    output logic                   wr_hit,
    output logic                   rd_hit
);
    import coh_msg_pkg::*;

    localparam int PTR_W = $clog2(`SNOOP_DEPTH);

    coh_msg_t                mem [`SNOOP_DEPTH];
    logic [`SNOOP_DEPTH-1:0] valid;
    logic [PTR_W:0]          wptr;  // msb is the wrap bit
    logic [PTR_W:0]          rptr;

    function automatic logic [PTR_W:0] ptr_inc(input logic [PTR_W:0] p);
        if (p[PTR_W-1:0] == PTR_W'(`SNOOP_DEPTH - 1)) begin
            return {~p[PTR_W], {PTR_W{1'b0}}};
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            valid <= '0;
        end else begin
            if (push) begin
                wptr                    <= ptr_inc(wptr);
                valid[wptr[PTR_W-1:0]] <= 1'b1;
            end
            if (pop) begin
                rptr                    <= ptr_inc(rptr);
                valid[rptr[PTR_W-1:0]] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr[PTR_W-1:0]] <= push_msg;
        end
    end

    assign head      = mem[rptr[PTR_W-1:0]];
    assign not_empty = wptr != rptr;

    // pending peer requests on the tracked lines
    always_comb begin
        wr_hit = 1'b0;
        rd_hit = 1'b0;
        for (int i = 0; i < `SNOOP_DEPTH; i++) begin
            if (valid[i] && mem[i].addr == wr_addr) begin
                wr_hit = 1'b1;
            end
            if (valid[i] && mem[i].addr == rd_addr) begin
                rd_hit = 1'b1;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the msg_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module msg_ctrl_tb -o msg_ctrl_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/msg_ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -q "^RESULT: PASS$" || exit 1
exit 0

// File: verification/msg_ctrl_tb.sv
`timescale 1ns/1ps
`include "coh_params.svh"

module msg_ctrl_tb;
    import coh_msg_pkg::*;
    import coh_ctrl_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         req_v [2];
    local_req_t   local_req_v [2];
    logic         gnt_0;
    logic         gnt_1;
    local_rsp_t   rsp_0;
    local_rsp_t   rsp_1;
    logic         rsp_valid_0;
    logic         rsp_valid_1;
    logic         acc_req;
    acc_req_t     acc;
    logic         acc_gnt;
    acc_rsp_t     acc_rsp;
    logic         fetch_req;
    fetch_req_t   fetch;
    logic         fetch_gnt;
    logic         fetch_done;
    logic         msg_req;
    logic         msg_gnt;
    coh_msg_t     msg;
    coh_msg_t     msg_in;
    logic         msg_in_valid;

    logic [31:0]  rng;
    int           cyc;
    int           errs;
    string        tname;

    // local port model
    logic         p_busy [2];
    logic         p_gnt [2];
    local_req_t   p_req [2];
    logic         shared_seen;  // shared ack sent to the read tracker
    int           loc_issued;
    int           loc_lim;
    int           loc_done;

    // peer and cache-array model
    coh_msg_t     in_q [$];
    int           in_due [$];
    coh_msg_t     snp_q [$];    // delivered peer requests, in arrival order
    logic         pr_out [`CACHE_NUM][2];
    acc_status_e  stat_tab [8];
    logic [1:0]   tag_tab [8];
    logic         lk_seen;
    logic         upd_seen;
    logic         wb_seen;
    int           fd_cnt;
    int           snp_issued;
    int           snp_lim;
    int           snp_done;

    msg_ctrl #(.cache_id(0)) msg_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_0        (req_v[0]),
        .req_1        (req_v[1]),
        .local_req_0  (local_req_v[0]),
        .local_req_1  (local_req_v[1]),
        .gnt_0        (gnt_0),
        .gnt_1        (gnt_1),
        .rsp_0        (rsp_0),
        .rsp_1        (rsp_1),
        .rsp_valid_0  (rsp_valid_0),
        .rsp_valid_1  (rsp_valid_1),
        .acc_req      (acc_req),
        .acc          (acc),
        .acc_gnt      (acc_gnt),
        .acc_rsp      (acc_rsp),
        .fetch_req    (fetch_req),
        .fetch        (fetch),
        .fetch_gnt    (fetch_gnt),
        .fetch_done   (fetch_done),
        .msg_req      (msg_req),
        .msg_gnt      (msg_gnt),
        .msg          (msg),
        .msg_in       (msg_in),
        .msg_in_valid (msg_in_valid)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic value_err(string what, logic [63:0] exp, logic [63:0] act);
        $display("error %s %s: expected %0h actual %0h", tname, what, exp, act);
        errs++;
    endtask

    task automatic other_err(string what);
        $display("%s: %s", tname, what);
        errs++;
    endtask

    always @(posedge clk) begin
        logic       gv [2];
        logic       rv [2];
        local_rsp_t rs [2];
        coh_msg_t   m;
        coh_msg_t   h;
        logic       found;
        msg_op_e    exp_op;
        logic [31:0] r;
        if (rst_n) begin
            cyc++;
            gv[0] = gnt_0;
            gv[1] = gnt_1;
            rv[0] = rsp_valid_0;
            rv[1] = rsp_valid_1;
            rs[0] = rsp_0;
            rs[1] = rsp_1;

            for (int p = 0; p < 2; p++) begin
                if (gv[p]) begin
                    if (!p_busy[p] || p_gnt[p]) begin
                        other_err($sformatf("grant on port %0d without a request", p));
                    end
                    p_gnt[p] = 1'b1;
                    req_v[p] <= 1'b0;
                end
                if (rv[p]) begin
                    if (!p_gnt[p]) begin
                        other_err($sformatf("response on port %0d with nothing granted", p));
                    end else begin
                        if (p_req[p].op == wr_req) exp_op = wr_ack;
                        else exp_op = shared_seen ? rd_share_ack : rd_ack;
                        if (rs[p].op != exp_op) value_err("local rsp op", exp_op, rs[p].op);
                        loc_done++;
                    end
                    p_busy[p] = 1'b0;
                    p_gnt[p]  = 1'b0;
                end else if (!p_busy[p] && loc_issued < loc_lim && rand32() % 4 == 0) begin
                    r = rand32();
                    p_busy[p]       = 1'b1;
                    p_req[p].op     = r[8] ? rd_req : wr_req;
                    p_req[p].index  = 32'(r[2:0]);
                    req_v[p]       <= 1'b1;
                    local_req_v[p] <= p_req[p];
                    loc_issued++;
                end
            end

            if (msg_req && msg_gnt) begin
                if (msg.op[2]) begin
                    if (msg.ta != 0) value_err("bcast ta", 0, msg.ta);
                    if (msg.ra != 2'b11) value_err("bcast ra", 3, msg.ra);
                    found = 1'b0;
                    for (int p = 0; p < 2; p++) begin
                        if (p_gnt[p] && p_req[p].op == msg.op && p_req[p].index == msg.addr)
                            found = 1'b1;
                    end
                    if (!found) other_err($sformatf("broadcast to %0h matches no grant", msg.addr));
                    foreach (snp_q[i]) begin
                        if (snp_q[i].addr == msg.addr)
                            other_err($sformatf("broadcast to %0h over a pending peer request",
                                                msg.addr));
                    end
                    // the network echoes our own broadcast back to us
                    in_q.push_back(msg);
                    in_due.push_back(cyc);
                    if (msg.op == rd_req) shared_seen = 1'b0;
                    for (int q = 1; q < `CACHE_NUM; q++) begin
                        r = rand32();
                        m.ta   = 2'(q);
                        m.ra   = 2'd0;
                        m.addr = msg.addr;
                        if (msg.op == wr_req) begin
                            m.op = wr_ack;
                        end else if (r[20]) begin
                            m.op = rd_share_ack;
                            shared_seen = 1'b1;
                        end else begin
                            m.op = rd_ack;
                        end
                        in_q.push_back(m);
                        in_due.push_back(cyc + 1 + int'(r[3:0]));
                    end
                end else if (snp_q.size() == 0) begin
                    other_err("snoop ack with no peer request pending");
                end else begin
                    h = snp_q.pop_front();
                    if (h.op == wr_req) exp_op = wr_ack;
                    else if (stat_tab[h.addr[2:0]] != acc_miss) exp_op = rd_share_ack;
                    else exp_op = rd_ack;
                    if (msg.op != exp_op) value_err("snoop ack op", exp_op, msg.op);
                    if (msg.ta != 0) value_err("snoop ack ta", 0, msg.ta);
                    if (msg.ra != h.ta) value_err("snoop ack ra", h.ta, msg.ra);
                    if (msg.addr != h.addr) value_err("snoop ack addr", h.addr, msg.addr);
                    if (!lk_seen) other_err("snoop ack without a lookup");
                    if (upd_seen != (stat_tab[h.addr[2:0]] != acc_miss))
                        value_err("line update done", stat_tab[h.addr[2:0]] != acc_miss, upd_seen);
                    if (wb_seen != (stat_tab[h.addr[2:0]] == acc_dirty))
                        value_err("writeback done", stat_tab[h.addr[2:0]] == acc_dirty, wb_seen);
                    pr_out[h.ta][h.op == rd_req] = 1'b0;
                    lk_seen  = 1'b0;
                    upd_seen = 1'b0;
                    wb_seen  = 1'b0;
                    snp_done++;
                end
            end
            msg_gnt <= !msg_gnt && msg_req && rand32() % 2 == 0;

            // peer request taken into the DUT queue this edge
            if (msg_in_valid && msg_in.op[2] && msg_in.ta != 2'd0) snp_q.push_back(msg_in);

            if (acc_req && acc_gnt) begin
                h = snp_q.size() > 0 ? snp_q[0] : '0;
                if (snp_q.size() == 0) other_err("array access with no peer request pending");
                if (acc.index != h.addr) value_err("acc index", h.addr, acc.index);
                if (acc.cmd == cmd_lookup) begin
                    lk_seen = 1'b1;
                end else begin
                    exp_op = h.op;  // request kind of the line update
                    if (acc.cmd != (exp_op == wr_req ? cmd_invalidate : cmd_downgrade))
                        value_err("update cmd", exp_op == wr_req ? cmd_invalidate : cmd_downgrade,
                                  acc.cmd);
                    if (acc.tag != tag_tab[h.addr[2:0]])
                        value_err("update tag", tag_tab[h.addr[2:0]], acc.tag);
                    upd_seen = 1'b1;
                end
            end
            acc_gnt <= !acc_gnt && acc_req && rand32() % 2 == 0;
            acc_rsp <= '{status: stat_tab[acc.index[2:0]], tag: tag_tab[acc.index[2:0]],
                         index: acc.index};

            if (fetch_req && fetch_gnt) begin
                h = snp_q.size() > 0 ? snp_q[0] : '0;
                if (stat_tab[h.addr[2:0]] != acc_dirty) other_err("writeback of a clean line");
                if (fetch.addr != h.addr) value_err("fetch addr", h.addr, fetch.addr);
                if (fetch.tag != tag_tab[h.addr[2:0]])
                    value_err("fetch tag", tag_tab[h.addr[2:0]], fetch.tag);
                wb_seen = 1'b1;
                fd_cnt  = 1 + int'(rand32() % 8);
            end
            fetch_gnt <= !fetch_gnt && fetch_req && rand32() % 2 == 0;
            if (fd_cnt > 0) begin
                fd_cnt--;
                fetch_done <= fd_cnt == 0;
            end else begin
                fetch_done <= 1'b0;
            end

            // new peer request, one read and one write per peer at most
            if (snp_issued < snp_lim && rand32() % 8 == 0) begin
                r = rand32();
                m.ta   = 2'(1 + r % 3);
                m.op   = r[12] ? rd_req : wr_req;
                m.ra   = 2'b11;
                m.addr = 32'(r[18:16]);
                if (!pr_out[m.ta][r[12]]) begin
                    pr_out[m.ta][r[12]] = 1'b1;
                    in_q.push_back(m);
                    in_due.push_back(cyc);
                    snp_issued++;
                end
            end

            found = 1'b0;
            for (int i = 0; i < in_q.size() && !found; i++) begin
                if (in_due[i] <= cyc) begin
                    msg_in <= in_q[i];
                    in_q.delete(i);
                    in_due.delete(i);
                    found = 1'b1;
                end
            end
            msg_in_valid <= found;
        end
    end

    task automatic run_test(string name, int n_loc, int n_snp);
        int e0;
        e0    = errs;
        tname = name;
        loc_lim += n_loc;
        snp_lim += n_snp;
        while (loc_done < loc_lim || snp_done < snp_lim) @(posedge clk);
        repeat (20) @(posedge clk);
        $display("test %s: %0d local, %0d snoop, %0d errors", name, n_loc, n_snp, errs - e0);
    endtask

    initial begin
        // 200 transactions over the three tests
        repeat (10 + 200 * 400) @(posedge clk);
        $display("timeout: transactions stopped completing");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        rng          = 32'hb270_f2dc;
        req_v[0]     = 1'b0;
        req_v[1]     = 1'b0;
        local_req_v[0] = '{op: rd_req, index: '0};
        local_req_v[1] = '{op: rd_req, index: '0};
        acc_gnt      = 1'b0;
        acc_rsp      = '{status: acc_miss, tag: '0, index: '0};
        fetch_gnt    = 1'b0;
        fetch_done   = 1'b0;
        msg_gnt      = 1'b0;
        msg_in       = '{op: wr_ack, ta: '0, ra: '0, addr: '0};
        msg_in_valid = 1'b0;
        shared_seen  = 1'b0;
        lk_seen      = 1'b0;
        upd_seen     = 1'b0;
        wb_seen      = 1'b0;
        fd_cnt       = 0;
        for (int i = 0; i < 2; i++) begin
            p_busy[i] = 1'b0;
            p_gnt[i]  = 1'b0;
        end
        for (int i = 0; i < `CACHE_NUM; i++) begin
            pr_out[i][0] = 1'b0;
            pr_out[i][1] = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            stat_tab[i] = acc_status_e'(rand32() % 4);
            tag_tab[i]  = 2'(rand32());
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        run_test("local_only", 40, 0);
        run_test("snoop_only", 0, 40);
        run_test("mixed", 60, 60);
        $display("tests 3, local %0d, snoop %0d, errors %0d", loc_done, snp_done, errs);
        if (errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
